// ==== nabp_cases.txt ====
# columns: s0 s1 s2 s3 in fill order, then expected pe_sums[0] pe_sums[1] pe_sums[2] pe_sums[3]
# one line per iteration in decimal, angle index 1, 2, 3 and so on
10 20 30 40 3508 6068 8628 11188
5 6 7 8 4064 6880 9696 12512
11 13 17 19 5932 9260 13100 16428
25 9 14 6 11308 10540 15660 16940
7 31 12 22 12152 17528 17784 21624
18 5 27 9 16036 18084 23972 23204
8 16 32 64 17136 21232 31216 38640
100 50 25 12 43760 35056 38640 42736
3 1 4 2 45476 36260 40612 44196
200 150 100 50 95952 73936 65488 56272

// ==== nabp_top.f ====
nabp_pkg.sv
nabp_swap_control.sv
nabp_state_control.sv
nabp_shifter.sv
nabp_pe_array.sv
nabp_top.sv
nabp_checker.sv
nabp_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module nabp_tb -f nabp_top.f -o nabp_sim
out=$(./obj_dir/nabp_sim)
echo "$out"
if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1

// ==== nabp_tb.sv ====
module nabp_tb
    import nabp_pkg::*;
();

    localparam int pe_width = 4;
    localparam int max_cases = 64;

    logic                 clk;
    logic                 reset_n;
    sample_t              sample_in;
    logic                 sample_valid;
    logic                 proj_ready;
    logic                 fill_active;
    logic                 proj_ack;
    acc_t [pe_width-1:0]  pe_sums;
    logic                 itr_done;
    logic [angle_len-1:0] itr_angle;
    acc_t [pe_width-1:0]  exp_sums;
    int                   errors;
    int                   checks;

    sample_t case_strips [max_cases][pe_width];
    acc_t    case_sums [max_cases][pe_width];
    int      n_cases = 0;
    int      seed = 92700;

    nabp_top #(
        .pe_width(pe_width)
    ) nabp_top_i (
        .clk(clk),
        .reset_n(reset_n),
        .sample_in(sample_in),
        .sample_valid(sample_valid),
        .proj_ready(proj_ready),
        .fill_active(fill_active),
        .proj_ack(proj_ack),
        .pe_sums(pe_sums),
        .itr_done(itr_done),
        .itr_angle(itr_angle)
    );

    nabp_checker #(
        .pe_width(pe_width)
    ) checker_i (
        .clk(clk),
        .reset_n(reset_n),
        .sample_in(sample_in),
        .sample_valid(sample_valid),
        .fill_active(fill_active),
        .proj_ready(proj_ready),
        .proj_ack(proj_ack),
        .pe_sums(pe_sums),
        .itr_done(itr_done),
        .itr_angle(itr_angle),
        .exp_sums(exp_sums),
        .errors(errors),
        .checks(checks)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic read_cases(output bit ok);
        int    fd;
        int    cnt;
        int    v [8];
        string line;
        ok = 1'b0;
        fd = $fopen("nabp_cases.txt", "r");
        if (fd != 0)
        begin
            while ($fgets(line, fd) != 0 && n_cases < max_cases)
            begin
                // comment lines do not scan as numbers
                cnt = $sscanf(line, "%d %d %d %d %d %d %d %d",
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
                if (cnt == 2 * pe_width)
                begin
                    for (int k = 0; k < pe_width; k++)
                    begin
                        case_strips[n_cases][k] = sample_t'(v[k]);
                        case_sums[n_cases][k] = acc_t'(v[pe_width + k]);
                    end
                    n_cases++;
                end
            end
            $fclose(fd);
            ok = (n_cases > 0);
        end
    endtask

    // host side of one strip with random gaps
    // junk strobes while the shifter is closed
    task automatic send_strip(input int idx);
        int k;
        int gap;
        k = 0;
        gap = $random(seed) & 3;
        while (k < pe_width)
        begin
            @(posedge clk);
            #1;
            sample_valid = 1'b0;
            if (fill_active && gap == 0)
            begin
                sample_in = case_strips[idx][k];
                sample_valid = 1'b1;
                k = k + 1;
                gap = $random(seed) & 3;
            end
            else if (fill_active)
                gap = gap - 1;
            else if (($random(seed) & 3) == 0)
            begin
                sample_in = 12'h5a5;
                sample_valid = 1'b1;
            end
        end
        @(posedge clk);
        #1;
        sample_valid = 1'b0;
    endtask

    task automatic grant_swap();
        int delay;
        delay = $random(seed) & 7;
        repeat (delay)
        begin
            @(posedge clk);
            #1;
            sample_in = 12'h3c3;
            sample_valid = (($random(seed) & 1) != 0);
        end
        sample_valid = 1'b0;
        proj_ready = 1'b1;
        do
            @(negedge clk);
        while (!proj_ack);
        @(posedge clk);
        #1;
        proj_ready = 1'b0;
    endtask

    task automatic wait_itr_done();
        do
            @(negedge clk);
        while (!itr_done);
        @(posedge clk);
        #1;
    endtask

    initial
    begin : main
        bit ok;
        reset_n = 1'b0;
        sample_in = '0;
        sample_valid = 1'b0;
        proj_ready = 1'b0;
        exp_sums = '0;
        read_cases(ok);
        if (!ok)
        begin
            $display("no usable cases in nabp_cases.txt");
            $display("tests failed");
            $finish;
        end
        else
        begin
            repeat (16) @(posedge clk);
            #1;
            reset_n = 1'b1;
            for (int i = 0; i < n_cases; i++)
            begin
                for (int k = 0; k < pe_width; k++)
                    exp_sums[k] = case_sums[i][k];
                send_strip(i);
                grant_swap();
                wait_itr_done();
            end
            repeat (4) @(posedge clk);
            $display("checks: %0d, errors: %0d", checks, errors);
            if (errors == 0)
                $display("all tests passed");
            else
                $display("tests failed");
            $finish;
        end
    end

    // limit grows with the number of cases
    initial
    begin : watchdog
        int limit;
        wait (n_cases > 0);
        limit = n_cases * pe_width * 40;
        repeat (limit) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles, the DUT hung", limit);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== nabp_checker.sv ====
module nabp_checker
    import nabp_pkg::*;
#(
    parameter int pe_width = 4
)
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  sample_t              sample_in,
    input  logic                 sample_valid,
    input  logic                 fill_active,
    input  logic                 proj_ready,
    input  logic                 proj_ack,
    input  acc_t [pe_width-1:0]  pe_sums,
    input  logic                 itr_done,
    input  logic [angle_len-1:0] itr_angle,
    // sums from the cases file for the running iteration
    input  acc_t [pe_width-1:0]  exp_sums,
    output int                   errors,
    output int                   checks
);

    sample_t              strip [pe_width];
    int                   model [pe_width] = '{default: 0};
    int                   err_cnt = 0;
    int                   check_cnt = 0;
    int                   fill_cnt = 0;
    int                   ack_cnt = 0;
    int                   ack_cycle = 0;
    int                   cycle = 0;
    int                   done_cnt = 0;
    logic [angle_len-1:0] exp_angle = angle_len'(1);

    assign errors = err_cnt;
    assign checks = check_cnt;

    task automatic check_value(input string name, input int got, input int want);
        check_cnt++;
        if (got != want)
        begin
            err_cnt++;
            $display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, name, got, want);
        end
    endtask

    task automatic report(input string what);
        err_cnt++;
        $display("error at t=%0t: %s", $time, what);
    endtask

    // falling edge lies midway between drive and capture
    always @(negedge clk)
    begin : watch
        int fact;
        cycle++;
        if (!reset_n)
        begin
            check_value("itr_done", int'(itr_done), 0);
            check_value("proj_ack", int'(proj_ack), 0);
            check_value("fill_active", int'(fill_active), 0);
        end
        // nothing published before the first iteration ends
        if (done_cnt == 0 && !itr_done)
        begin
            for (int k = 0; k < pe_width; k++)
                check_value($sformatf("pe_sums[%0d]", k), int'(pe_sums[k]), 0);
        end
        if (reset_n)
        begin
            // k-th sample taken while the shifter is open belongs to element k
            if (fill_active && sample_valid)
            begin
                strip[fill_cnt] = sample_in;
                fill_cnt = (fill_cnt + 1) % pe_width;
            end
            if (proj_ack)
            begin
                check_cnt++;
                if (!proj_ready)
                    report("proj_ack while proj_ready is low");
                ack_cnt++;
                ack_cycle = cycle;
            end
            if (itr_done)
            begin
                // unit trig value scaled by the line count
                fact = int'(trig_table[exp_angle]) * pe_width;
                check_value("itr_angle", int'(itr_angle), int'(exp_angle));
                for (int k = 0; k < pe_width; k++)
                begin
                    model[k] = model[k] + int'(strip[k]) * 256 + fact;
                    check_value($sformatf("pe_sums[%0d]", k), int'(pe_sums[k]), model[k]);
                    check_value($sformatf("pe_sums[%0d] vs cases file", k),
                                int'(pe_sums[k]), int'(exp_sums[k]));
                end
                check_cnt += 2;
                if (ack_cnt != 1)
                    report($sformatf("%0d proj_ack pulses in iteration %0d, expected one",
                                     ack_cnt, done_cnt));
                if (cycle - ack_cycle != pe_width + 1)
                    report($sformatf("itr_done came %0d cycles after proj_ack, expected %0d",
                                     cycle - ack_cycle, pe_width + 1));
                ack_cnt = 0;
                exp_angle = exp_angle + 1'b1;
                done_cnt++;
            end
        end
    end

endmodule

// ==== nabp_top.sv ====
module nabp_top
    import nabp_pkg::*;
#(
    parameter int pe_width = 4
)
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  sample_t              sample_in,
    input  logic                 sample_valid,
    input  logic                 proj_ready,
    output logic                 fill_active,
    output logic                 proj_ack,
    output acc_t [pe_width-1:0]  pe_sums,
    output logic                 itr_done,
    output logic [angle_len-1:0] itr_angle
);

    itr_data_t next_itr;
    itr_data_t cur_itr;
    logic      next_itr_req;
    logic      swap_ready;
    logic      swap;
    logic      fill_kick;
    logic      shift_kick;
    logic      fill_done;
    logic      shift_valid;
    sample_t   shift_sample;
    logic      shift_done;

    // producer of iteration data
    nabp_swap_control #(
        .pe_width(pe_width)
    ) swap_control_i (
        .clk(clk),
        .reset_n(reset_n),
        .next_itr_req(next_itr_req),
        .swap_ready(swap_ready),
        .proj_ready(proj_ready),
        .next_itr(next_itr),
        .swap(swap),
        .proj_ack(proj_ack)
    );

    nabp_state_control state_control_i (
        .clk(clk),
        .reset_n(reset_n),
        .next_itr(next_itr),
        .swap(swap),
        .fill_done(fill_done),
        .shift_done(shift_done),
        .cur_itr(cur_itr),
        .next_itr_req(next_itr_req),
        .swap_ready(swap_ready),
        .fill_kick(fill_kick),
        .shift_kick(shift_kick)
    );

    nabp_shifter #(
        .pe_width(pe_width)
    ) shifter_i (
        .clk(clk),
        .reset_n(reset_n),
        .fill_kick(fill_kick),
        .shift_kick(shift_kick),
        .sample_in(sample_in),
        .sample_valid(sample_valid),
        .fill_active(fill_active),
        .fill_done(fill_done),
        .shift_valid(shift_valid),
        .shift_sample(shift_sample),
        .shift_done(shift_done)
    );

    // consumer row
    nabp_pe_array #(
        .pe_width(pe_width)
    ) pe_array_i (
        .clk(clk),
        .reset_n(reset_n),
        .cur_itr(cur_itr),
        .shift_valid(shift_valid),
        .shift_sample(shift_sample),
        .shift_done(shift_done),
        .pe_sums(pe_sums),
        .itr_done(itr_done),
        .itr_angle(itr_angle)
    );

endmodule

// ==== nabp_pe_array.sv ====
module nabp_pe_array
    import nabp_pkg::*;
#(
    parameter int pe_width = 4
)
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  itr_data_t            cur_itr,
    // stream from the shifter
    input  logic                 shift_valid,
    input  sample_t              shift_sample,
    input  logic                 shift_done,
    // published results
    output acc_t [pe_width-1:0]  pe_sums,
    output logic                 itr_done,
    output logic [angle_len-1:0] itr_angle
);

    localparam int idx_len = (pe_width > 1) ? $clog2(pe_width) : 1;

    logic [idx_len-1:0] pe_idx;
    acc_t               acc [pe_width];
    acc_t               acc_next [pe_width];
    acc_t               term;

    always_comb
    begin
        // sample lifted to 8 fraction bits plus the line-count factor
        term = (acc_t'(shift_sample) <<< fact_frac_len) + acc_t'(cur_itr.fact);
        for (int k = 0; k < pe_width; k++)
        begin
            acc_next[k] = acc[k];
            if (shift_valid && (pe_idx == idx_len'(k)))
                acc_next[k] = acc[k] + term;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            pe_idx   <= '0;
            itr_done <= 1'b0;
            for (int k = 0; k < pe_width; k++)
            begin
                acc[k]     <= '0;
                pe_sums[k] <= '0;
            end
        end
        else
        begin
            itr_done <= shift_done;
            if (shift_done)
                pe_idx <= '0;
            else if (shift_valid)
                pe_idx <= pe_idx + 1'b1;
            for (int k = 0; k < pe_width; k++)
            begin
                acc[k] <= acc_next[k];
                // publish including the last sample of the strip
                if (shift_done)
                    pe_sums[k] <= acc_next[k];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (shift_done)
            itr_angle <= cur_itr.angle;
    end

endmodule

// ==== nabp_shifter.sv ====
module nabp_shifter
    import nabp_pkg::*;
#(
    parameter int pe_width = 4
)
(
    input  logic    clk,
    input  logic    reset_n,
    // kicks from the sequencer
    input  logic    fill_kick,
    input  logic    shift_kick,
    // host samples
    input  sample_t sample_in,
    input  logic    sample_valid,
    output logic    fill_active,
    output logic    fill_done,
    // stream into the pe row
    output logic    shift_valid,
    output sample_t shift_sample,
    output logic    shift_done
);

    localparam int idx_len = (pe_width > 1) ? $clog2(pe_width) : 1;
    localparam logic [idx_len-1:0] last_idx = idx_len'(pe_width - 1);

    sample_t            strip [pe_width];
    logic [idx_len-1:0] idx;
    logic               shift_active;
    logic               take_sample;
    logic               at_last;

    assign take_sample = fill_active && sample_valid;
    assign at_last     = (idx == last_idx);

    // one index serves both phases since they never overlap
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            idx          <= '0;
            fill_active  <= 1'b0;
            fill_done    <= 1'b0;
            shift_active <= 1'b0;
        end
        else
        begin
            fill_done <= take_sample && at_last;
            if (fill_kick)
            begin
                idx         <= '0;
                fill_active <= 1'b1;
            end
            else if (take_sample)
            begin
                idx <= at_last ? '0 : idx + 1'b1;
                if (at_last)
                    fill_active <= 1'b0;
            end
            else if (shift_kick)
            begin
                idx          <= '0;
                shift_active <= 1'b1;
            end
            else if (shift_active)
            begin
                idx <= at_last ? '0 : idx + 1'b1;
                if (at_last)
                    shift_active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (take_sample)
            strip[idx] <= sample_in;
    end

    // first sample goes out the cycle after the kick
    assign shift_valid  = shift_active;
    assign shift_sample = strip[idx];
    assign shift_done   = shift_active && at_last;

endmodule

// ==== nabp_state_control.sv ====
module nabp_state_control
    import nabp_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    // from swap control
    input  itr_data_t next_itr,
    input  logic      swap,
    // from shifter
    input  logic      fill_done,
    input  logic      shift_done,
    // iteration data held for the pe row
    output itr_data_t cur_itr,
    // to swap control
    output logic      next_itr_req,
    output logic      swap_ready,
    // to shifter
    output logic      fill_kick,
    output logic      shift_kick
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= init_s;
        else
            state <= next_state;
    end

    // iteration data only changes in setup
    always_ff @(posedge clk)
    begin
        if (state == setup_s)
            cur_itr <= next_itr;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            init_s:
                next_state = setup_s;
            setup_s:
                next_state = fill_s;
            fill_s:
                if (fill_done)
                    next_state = fill_done_s;
            fill_done_s:
                if (swap)
                    next_state = shift_s;
            shift_s:
                if (shift_done)
                    next_state = shift_done_s;
            shift_done_s:
                next_state = setup_s;
            default:
                next_state = init_s;
        endcase
    end

    // outputs from state and next state
    assign swap_ready   = (state == fill_done_s);
    assign next_itr_req = (state == init_s) || (state == shift_done_s);
    assign fill_kick    = (next_state != state) && (next_state == fill_s);
    assign shift_kick   = (next_state != state) && (next_state == shift_s);

endmodule

// ==== nabp_swap_control.sv ====
module nabp_swap_control
    import nabp_pkg::*;
#(
    parameter int pe_width = 4
)
(
    input  logic      clk,
    input  logic      reset_n,
    // request from the sequencer
    input  logic      next_itr_req,
    input  logic      swap_ready,
    // host side
    input  logic      proj_ready,
    output itr_data_t next_itr,
    output logic      swap,
    output logic      proj_ack
);

    localparam int pe_width_len = $clog2(pe_width);

    logic [angle_len-1:0] angle_idx;
    logic [angle_len-1:0] angle_step;
    fact_t                line_cnt_fact;
    logic                 grant;

    // index wraps modulo eight by its width
    assign angle_step = angle_idx + 1'b1;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            angle_idx     <= '0;
            line_cnt_fact <= trig_table[0] <<< pe_width_len;
        end
        else if (next_itr_req)
        begin
            angle_idx <= angle_step;
            // factor scaled by the line count, a power of two
            line_cnt_fact <= trig_table[angle_step] <<< pe_width_len;
        end
    end

    assign next_itr.angle = angle_idx;
    assign next_itr.fact  = line_cnt_fact;

    // swap_ready drops as soon as the sequencer moves to shift,
    // so the grant is one cycle wide and happens once per iteration
    assign grant    = swap_ready && proj_ready;
    assign swap     = grant;
    assign proj_ack = grant;

endmodule

// ==== nabp_pkg.sv ====
package nabp_pkg;

    // word widths
    localparam int angle_len = 3;
    localparam int sample_len = 12;
    localparam int fact_int_len = 6;
    localparam int fact_frac_len = 8;
    localparam int acc_len = 24;

    typedef logic signed [sample_len-1:0] sample_t;
    typedef logic signed [fact_int_len+fact_frac_len-1:0] fact_t;
    typedef logic signed [acc_len-1:0] acc_t;

    // data that the sequencer holds for one iteration
    typedef struct packed {
        logic [angle_len-1:0] angle;
        fact_t                fact;
    } itr_data_t;

    typedef enum logic [2:0] {
        init_s,
        setup_s,
        fill_s,
        fill_done_s,
        shift_s,
        shift_done_s
    } ctrl_state_t;

    // angle i is i * 22.5 deg
    // entries carry 8 fraction bits
    // cos for 0, 1, 6, 7 and -sin for 2 to 5
    localparam fact_t trig_table [8] = '{
        14'sd256,
        14'sd237,
        -14'sd181,
        -14'sd237,
        -14'sd256,
        -14'sd237,
        -14'sd181,
        -14'sd237
    };

endpackage
